// ==== hdl/bus_pkg.sv ====
// AXI-lite bus types, response codes and the system address map
package bus_pkg;
	typedef logic [31:0] addr_t;	// Byte address
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_DECERR = 2'd3;

	localparam addr_t MEM_BASE = 32'h0000_0000;
	localparam int MEM_ADDR_BITS = 12;
	localparam int MEM_WORDS = 1 << (MEM_ADDR_BITS - 2);	// 1024 words
	localparam addr_t GFX_BASE = 32'h0200_0000;
	localparam int GFX_ADDR_BITS = 8;

	// Replace the byte lanes of old selected by strb
	function automatic data_t strb_merge(data_t old, data_t data, strb_t strb);
		data_t res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction
endpackage

// ==== hdl/gfx_pkg.sv ====
// Graphics register offsets and pixel path types
package gfx_pkg;
	typedef logic [31:0] pixel_t;
	typedef logic [15:0] count_t;	// Completed frames, wraps

	localparam logic [7:0] REG_CTRL = 8'h00;	// Bit 0 enable
	localparam logic [7:0] REG_FB_BASE = 8'h04;
	localparam logic [7:0] REG_LINE_WORDS = 8'h08;
	localparam logic [7:0] REG_STATUS = 8'h0C;	// Bit 16 busy over frame count
endpackage

// ==== hdl/axil_ram.sv ====
// AXI-lite word memory with byte strobes, one transaction at a time
module axil_ram import bus_pkg::*; (
	input logic hdmi_pixClk,
	input logic rst,
	input logic aw_valid,
	output logic aw_ready,
	input addr_t aw_addr,
	input logic w_valid,
	output logic w_ready,
	input data_t w_data,
	input strb_t w_strb,
	output logic b_valid,
	input logic b_ready,
	output resp_t b_resp,
	input logic ar_valid,
	output logic ar_ready,
	input addr_t ar_addr,
	output logic r_valid,
	input logic r_ready,
	output data_t r_data,
	output resp_t r_resp
);
	data_t mem [MEM_WORDS];
	logic idle;
	logic wr_fire;
	logic rd_fire;
	logic [MEM_ADDR_BITS-3:0] wr_idx;
	logic [MEM_ADDR_BITS-3:0] rd_idx;

	assign idle = !aw_ready && !ar_ready && !b_valid && !r_valid;
	assign wr_fire = aw_valid && aw_ready && w_valid && w_ready;
	assign rd_fire = ar_valid && ar_ready;
	assign w_ready = aw_ready;	// Address and data taken together
	assign wr_idx = aw_addr[MEM_ADDR_BITS-1:2];
	assign rd_idx = ar_addr[MEM_ADDR_BITS-1:2];
	assign b_resp = RESP_OKAY;
	assign r_resp = RESP_OKAY;

	always_ff @(posedge hdmi_pixClk) begin
		if (rst) begin
			aw_ready <= 1'b0;
			ar_ready <= 1'b0;
			b_valid <= 1'b0;
			r_valid <= 1'b0;
		end else begin
			aw_ready <= 1'b0;
			ar_ready <= 1'b0;
			if (idle && ar_valid)
				ar_ready <= 1'b1;	// Read wins
			else if (idle && aw_valid && w_valid)
				aw_ready <= 1'b1;

			if (wr_fire)
				b_valid <= 1'b1;
			else if (b_ready)
				b_valid <= 1'b0;

			if (rd_fire)
				r_valid <= 1'b1;
			else if (r_ready)
				r_valid <= 1'b0;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (wr_fire)
			mem[wr_idx] <= strb_merge(mem[wr_idx], w_data, w_strb);
		if (rd_fire)
			r_data <= mem[rd_idx];
	end

	// Single outstanding transaction
	assert property (@(posedge hdmi_pixClk) disable iff (rst) !(b_valid && r_valid));
endmodule

// ==== hdl/axil_interconnect.sv ====
// AXI-lite interconnect, two masters arbitrated round-robin onto two decoded slaves
module axil_interconnect import bus_pkg::*; (
	input logic hdmi_pixClk,
	input logic rst,
	input logic m0_aw_valid, output logic m0_aw_ready, input addr_t m0_aw_addr,
	input logic m0_w_valid, output logic m0_w_ready,
	input data_t m0_w_data, input strb_t m0_w_strb,
	output logic m0_b_valid, input logic m0_b_ready, output resp_t m0_b_resp,
	input logic m0_ar_valid, output logic m0_ar_ready, input addr_t m0_ar_addr,
	output logic m0_r_valid, input logic m0_r_ready,
	output data_t m0_r_data, output resp_t m0_r_resp,
	input logic m1_aw_valid, output logic m1_aw_ready, input addr_t m1_aw_addr,
	input logic m1_w_valid, output logic m1_w_ready,
	input data_t m1_w_data, input strb_t m1_w_strb,
	output logic m1_b_valid, input logic m1_b_ready, output resp_t m1_b_resp,
	input logic m1_ar_valid, output logic m1_ar_ready, input addr_t m1_ar_addr,
	output logic m1_r_valid, input logic m1_r_ready,
	output data_t m1_r_data, output resp_t m1_r_resp,
	output logic s0_aw_valid, input logic s0_aw_ready, output addr_t s0_aw_addr,
	output logic s0_w_valid, input logic s0_w_ready,
	output data_t s0_w_data, output strb_t s0_w_strb,
	input logic s0_b_valid, output logic s0_b_ready, input resp_t s0_b_resp,
	output logic s0_ar_valid, input logic s0_ar_ready, output addr_t s0_ar_addr,
	input logic s0_r_valid, output logic s0_r_ready,
	input data_t s0_r_data, input resp_t s0_r_resp,
	output logic s1_aw_valid, input logic s1_aw_ready, output addr_t s1_aw_addr,
	output logic s1_w_valid, input logic s1_w_ready,
	output data_t s1_w_data, output strb_t s1_w_strb,
	input logic s1_b_valid, output logic s1_b_ready, input resp_t s1_b_resp,
	output logic s1_ar_valid, input logic s1_ar_ready, output addr_t s1_ar_addr,
	input logic s1_r_valid, output logic s1_r_ready,
	input data_t s1_r_data, input resp_t s1_r_resp
);
	typedef enum logic [1:0] {IDLE, FWD, RESP, ERR} state_t;

	state_t state;
	logic last_grant;
	logic sel;	// Granted master
	logic rd;
	logic ack;
	addr_t addr_q;
	data_t data_q;
	strb_t strb_q;
	logic req0, req1, gnt, g_rd;
	addr_t g_addr;
	data_t g_data;
	strb_t g_strb;
	logic hit0, hit1, tgt, fwd;
	logic s_ar_ready, s_aw_ready, s_b_valid, s_r_valid;
	logic fwd_done, resp_valid, resp_done, g_b_ready, g_r_ready;
	resp_t resp_b, resp_r;
	data_t resp_data;

	function automatic logic in_window(addr_t a, addr_t base, int bits);
		return (a >> bits) == (base >> bits);
	endfunction

	// Arbitration, the master not granted last wins a tie
	assign req0 = m0_ar_valid || (m0_aw_valid && m0_w_valid);
	assign req1 = m1_ar_valid || (m1_aw_valid && m1_w_valid);
	assign gnt = (req0 && req1) ? !last_grant : req1;
	assign g_rd = gnt ? m1_ar_valid : m0_ar_valid;
	assign g_addr = g_rd ? (gnt ? m1_ar_addr : m0_ar_addr) : (gnt ? m1_aw_addr : m0_aw_addr);
	assign g_data = gnt ? m1_w_data : m0_w_data;
	assign g_strb = gnt ? m1_w_strb : m0_w_strb;

	assign hit0 = in_window(addr_q, MEM_BASE, MEM_ADDR_BITS);
	assign hit1 = in_window(addr_q, GFX_BASE, GFX_ADDR_BITS);
	assign tgt = hit1;
	assign fwd = state == FWD;

	assign s0_ar_valid = fwd && rd && hit0;
	assign s0_aw_valid = fwd && !rd && hit0;
	assign s0_w_valid = s0_aw_valid;
	assign s1_ar_valid = fwd && rd && hit1;
	assign s1_aw_valid = fwd && !rd && hit1;
	assign s1_w_valid = s1_aw_valid;
	assign s0_ar_addr = addr_q;
	assign s0_aw_addr = addr_q;
	assign s0_w_data = data_q;
	assign s0_w_strb = strb_q;
	assign s1_ar_addr = addr_q;
	assign s1_aw_addr = addr_q;
	assign s1_w_data = data_q;
	assign s1_w_strb = strb_q;

	assign s_ar_ready = tgt ? s1_ar_ready : s0_ar_ready;
	assign s_aw_ready = tgt ? (s1_aw_ready && s1_w_ready) : (s0_aw_ready && s0_w_ready);
	assign s_b_valid = tgt ? s1_b_valid : s0_b_valid;
	assign s_r_valid = tgt ? s1_r_valid : s0_r_valid;
	assign fwd_done = rd ? s_ar_ready : s_aw_ready;

	// Response path, DECERR comes from here
	assign g_b_ready = sel ? m1_b_ready : m0_b_ready;
	assign g_r_ready = sel ? m1_r_ready : m0_r_ready;
	assign resp_valid = (state == ERR) || (state == RESP && (rd ? s_r_valid : s_b_valid));
	assign resp_done = resp_valid && (rd ? g_r_ready : g_b_ready);
	assign resp_b = (state == ERR) ? RESP_DECERR : (tgt ? s1_b_resp : s0_b_resp);
	assign resp_r = (state == ERR) ? RESP_DECERR : (tgt ? s1_r_resp : s0_r_resp);
	assign resp_data = (state == ERR) ? '0 : (tgt ? s1_r_data : s0_r_data);
	assign s0_b_ready = state == RESP && !rd && !tgt && g_b_ready;
	assign s0_r_ready = state == RESP && rd && !tgt && g_r_ready;
	assign s1_b_ready = state == RESP && !rd && tgt && g_b_ready;
	assign s1_r_ready = state == RESP && rd && tgt && g_r_ready;

	assign m0_ar_ready = ack && !sel && rd;
	assign m0_aw_ready = ack && !sel && !rd;
	assign m0_w_ready = m0_aw_ready;
	assign m0_b_valid = resp_valid && !sel && !rd;
	assign m0_r_valid = resp_valid && !sel && rd;
	assign m0_b_resp = resp_b;
	assign m0_r_resp = resp_r;
	assign m0_r_data = resp_data;
	assign m1_ar_ready = ack && sel && rd;
	assign m1_aw_ready = ack && sel && !rd;
	assign m1_w_ready = m1_aw_ready;
	assign m1_b_valid = resp_valid && sel && !rd;
	assign m1_r_valid = resp_valid && sel && rd;
	assign m1_b_resp = resp_b;
	assign m1_r_resp = resp_r;
	assign m1_r_data = resp_data;

	always_ff @(posedge hdmi_pixClk) begin
		if (rst) begin
			state <= IDLE;
			last_grant <= 1'b1;	// m0 takes the first tie
			sel <= 1'b0;
			rd <= 1'b0;
			ack <= 1'b0;
		end else begin
			ack <= 1'b0;
			case (state)
				IDLE: if (req0 || req1) begin
					state <= FWD;
					sel <= gnt;
					last_grant <= gnt;
					rd <= g_rd;
					ack <= 1'b1;
				end
				FWD: if (!(hit0 || hit1))
					state <= ERR;
				else if (fwd_done)
					state <= RESP;
				RESP, ERR: if (resp_done)
					state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Request payload follows the winner until the grant
	always_ff @(posedge hdmi_pixClk) begin
		if (state == IDLE) begin
			addr_q <= g_addr;
			data_q <= g_data;
			strb_q <= g_strb;
		end
	end

	// Grant is taken a cycle late so the master must still hold its request
	assert property (@(posedge hdmi_pixClk) disable iff (rst)
		m0_ar_ready || m0_aw_ready |-> (rd ? m0_ar_valid : m0_aw_valid && m0_w_valid));
	assert property (@(posedge hdmi_pixClk) disable iff (rst)
		m1_ar_ready || m1_aw_ready |-> (rd ? m1_ar_valid : m1_aw_valid && m1_w_valid));
	assert property (@(posedge hdmi_pixClk) disable iff (rst)
		state == IDLE |-> !(s0_ar_valid || s0_aw_valid || s1_ar_valid || s1_aw_valid));
endmodule

// ==== hdl/gfx_regs.sv ====
// Graphics control and status registers on an AXI-lite slave port
module gfx_regs import bus_pkg::*, gfx_pkg::*; (
	input logic hdmi_pixClk,
	input logic rst,
	input logic aw_valid,
	output logic aw_ready,
	input addr_t aw_addr,
	input logic w_valid,
	output logic w_ready,
	input data_t w_data,
	input strb_t w_strb,
	output logic b_valid,
	input logic b_ready,
	output resp_t b_resp,
	input logic ar_valid,
	output logic ar_ready,
	input addr_t ar_addr,
	output logic r_valid,
	input logic r_ready,
	output data_t r_data,
	output resp_t r_resp,
	output logic enable,
	output addr_t fb_base,
	output data_t line_words,
	input logic frame_done,
	input logic busy
);
	count_t frame_count;
	logic idle, wr_fire, rd_fire;
	data_t wr_ctrl, wr_fb, wr_lines;

	assign idle = !aw_ready && !ar_ready && !b_valid && !r_valid;
	assign wr_fire = aw_valid && aw_ready && w_valid && w_ready;
	assign rd_fire = ar_valid && ar_ready;
	assign w_ready = aw_ready;
	assign b_resp = RESP_OKAY;	// Unknown offsets too
	assign r_resp = RESP_OKAY;

	assign wr_ctrl = strb_merge({31'b0, enable}, w_data, w_strb);
	assign wr_fb = strb_merge(fb_base, w_data, w_strb);
	assign wr_lines = strb_merge(line_words, w_data, w_strb);

	always_ff @(posedge hdmi_pixClk) begin
		if (rst) begin
			aw_ready <= 1'b0;
			ar_ready <= 1'b0;
			b_valid <= 1'b0;
			r_valid <= 1'b0;
			enable <= 1'b0;
			fb_base <= '0;
			line_words <= '0;
			frame_count <= '0;
		end else begin
			aw_ready <= 1'b0;
			ar_ready <= 1'b0;
			if (idle && ar_valid)
				ar_ready <= 1'b1;
			else if (idle && aw_valid && w_valid)
				aw_ready <= 1'b1;
			if (wr_fire)
				b_valid <= 1'b1;
			else if (b_ready)
				b_valid <= 1'b0;
			if (rd_fire)
				r_valid <= 1'b1;
			else if (r_ready)
				r_valid <= 1'b0;

			if (wr_fire) begin
				case (aw_addr[GFX_ADDR_BITS-1:0])
					REG_CTRL: enable <= wr_ctrl[0];
					REG_FB_BASE: fb_base <= wr_fb;
					REG_LINE_WORDS: line_words <= wr_lines;
					default: ;	// STATUS is read only
				endcase
			end
			if (frame_done)
				frame_count <= frame_count + 1'b1;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (rd_fire) begin
			case (ar_addr[GFX_ADDR_BITS-1:0])
				REG_CTRL: r_data <= {31'b0, enable};
				REG_FB_BASE: r_data <= fb_base;
				REG_LINE_WORDS: r_data <= line_words;
				REG_STATUS: r_data <= {15'b0, busy, frame_count};
				default: r_data <= '0;
			endcase
		end
	end
endmodule

// ==== hdl/scanout_fetch.sv ====
// Scanout engine reading frame words over AXI-lite and emitting them as pixels
module scanout_fetch import bus_pkg::*, gfx_pkg::*; (
	input logic hdmi_pixClk,
	input logic rst,
	input logic enable,
	input addr_t fb_base,
	input data_t line_words,
	output logic ar_valid,
	input logic ar_ready,
	output addr_t ar_addr,
	input logic r_valid,
	output logic r_ready,
	input data_t r_data,
	input resp_t r_resp,
	output logic aw_valid,
	output addr_t aw_addr,
	output logic w_valid,
	output data_t w_data,
	output strb_t w_strb,
	output logic b_ready,
	output logic busy,
	output logic pixel_valid,
	output pixel_t pixel_word,
	output logic frame_done
);
	typedef enum logic [1:0] {IDLE, ADDR, DATA} state_t;

	state_t state;
	addr_t addr_q;
	data_t idx;
	data_t last_idx;

	// Read only master
	assign aw_valid = 1'b0;
	assign aw_addr = '0;
	assign w_valid = 1'b0;
	assign w_data = '0;
	assign w_strb = '0;
	assign b_ready = 1'b1;

	assign ar_valid = state == ADDR;
	assign ar_addr = addr_q;
	assign r_ready = state == DATA;	// No pixel back-pressure
	assign busy = state != IDLE;

	always_ff @(posedge hdmi_pixClk) begin
		if (rst) begin
			state <= IDLE;
			pixel_valid <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			pixel_valid <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				IDLE: if (enable && line_words != '0)
					state <= ADDR;
				ADDR: if (ar_ready)
					state <= DATA;
				DATA: if (r_valid) begin
					pixel_valid <= 1'b1;
					frame_done <= idx == last_idx;
					state <= (idx == last_idx) ? IDLE : ADDR;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Settings snapshot while idle, then walk the frame
	always_ff @(posedge hdmi_pixClk) begin
		if (state == IDLE) begin
			addr_q <= {fb_base[31:2], 2'b00};
			last_idx <= line_words - 1'b1;
			idx <= '0;
		end
		if (state == DATA && r_valid) begin
			pixel_word <= (r_resp == RESP_OKAY) ? r_data : '0;
			addr_q <= addr_q + 32'd4;
			idx <= idx + 1'b1;
		end
	end

	// Read address held until accepted
	assert property (@(posedge hdmi_pixClk) disable iff (rst)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));
	// Interconnect only returns data for the read in flight
	assert property (@(posedge hdmi_pixClk) disable iff (rst) r_valid |-> state == DATA);
endmodule

// ==== hdl/soc_top.sv ====
// SoC top joining the command port and scanout to memory and graphics registers
module soc_top import bus_pkg::*, gfx_pkg::*; (
	input logic hdmi_pixClk,
	input logic rst,
	input logic cmd_aw_valid,
	input addr_t cmd_aw_addr,
	input logic cmd_w_valid,
	input data_t cmd_w_data,
	input strb_t cmd_w_strb,
	input logic cmd_b_ready,
	input logic cmd_ar_valid,
	input addr_t cmd_ar_addr,
	input logic cmd_r_ready,
	output logic cmd_aw_ready,
	output logic cmd_w_ready,
	output logic cmd_b_valid,
	output resp_t cmd_b_resp,
	output logic cmd_ar_ready,
	output logic cmd_r_valid,
	output data_t cmd_r_data,
	output resp_t cmd_r_resp,
	output logic pixel_valid,
	output pixel_t pixel_word,
	output logic frame_done
);
	// Scanout master
	logic m1_aw_valid, m1_w_valid, m1_b_ready;
	logic m1_ar_valid, m1_ar_ready, m1_r_valid, m1_r_ready;
	addr_t m1_aw_addr, m1_ar_addr;
	data_t m1_w_data, m1_r_data;
	strb_t m1_w_strb;
	resp_t m1_r_resp;
	// Memory
	logic s0_aw_valid, s0_aw_ready, s0_w_valid, s0_w_ready, s0_b_valid, s0_b_ready;
	logic s0_ar_valid, s0_ar_ready, s0_r_valid, s0_r_ready;
	addr_t s0_aw_addr, s0_ar_addr;
	data_t s0_w_data, s0_r_data;
	strb_t s0_w_strb;
	resp_t s0_b_resp, s0_r_resp;
	// Graphics registers
	logic s1_aw_valid, s1_aw_ready, s1_w_valid, s1_w_ready, s1_b_valid, s1_b_ready;
	logic s1_ar_valid, s1_ar_ready, s1_r_valid, s1_r_ready;
	addr_t s1_aw_addr, s1_ar_addr;
	data_t s1_w_data, s1_r_data;
	strb_t s1_w_strb;
	resp_t s1_b_resp, s1_r_resp;
	logic enable, busy;
	addr_t fb_base;
	data_t line_words;

	axil_interconnect u_ic (
		.m0_aw_valid(cmd_aw_valid), .m0_aw_ready(cmd_aw_ready), .m0_aw_addr(cmd_aw_addr),
		.m0_w_valid(cmd_w_valid), .m0_w_ready(cmd_w_ready),
		.m0_w_data(cmd_w_data), .m0_w_strb(cmd_w_strb),
		.m0_b_valid(cmd_b_valid), .m0_b_ready(cmd_b_ready), .m0_b_resp(cmd_b_resp),
		.m0_ar_valid(cmd_ar_valid), .m0_ar_ready(cmd_ar_ready), .m0_ar_addr(cmd_ar_addr),
		.m0_r_valid(cmd_r_valid), .m0_r_ready(cmd_r_ready),
		.m0_r_data(cmd_r_data), .m0_r_resp(cmd_r_resp),
		.m1_aw_ready(), .m1_w_ready(), .m1_b_valid(), .m1_b_resp(),	// Scanout never writes
		.*
	);

	axil_ram u_ram (
		.hdmi_pixClk, .rst,
		.aw_valid(s0_aw_valid), .aw_ready(s0_aw_ready), .aw_addr(s0_aw_addr),
		.w_valid(s0_w_valid), .w_ready(s0_w_ready), .w_data(s0_w_data), .w_strb(s0_w_strb),
		.b_valid(s0_b_valid), .b_ready(s0_b_ready), .b_resp(s0_b_resp),
		.ar_valid(s0_ar_valid), .ar_ready(s0_ar_ready), .ar_addr(s0_ar_addr),
		.r_valid(s0_r_valid), .r_ready(s0_r_ready), .r_data(s0_r_data), .r_resp(s0_r_resp)
	);

	gfx_regs u_regs (
		.hdmi_pixClk, .rst,
		.aw_valid(s1_aw_valid), .aw_ready(s1_aw_ready), .aw_addr(s1_aw_addr),
		.w_valid(s1_w_valid), .w_ready(s1_w_ready), .w_data(s1_w_data), .w_strb(s1_w_strb),
		.b_valid(s1_b_valid), .b_ready(s1_b_ready), .b_resp(s1_b_resp),
		.ar_valid(s1_ar_valid), .ar_ready(s1_ar_ready), .ar_addr(s1_ar_addr),
		.r_valid(s1_r_valid), .r_ready(s1_r_ready), .r_data(s1_r_data), .r_resp(s1_r_resp),
		.enable, .fb_base, .line_words, .frame_done, .busy
	);

	scanout_fetch u_scan (
		.hdmi_pixClk, .rst, .enable, .fb_base, .line_words,
		.ar_valid(m1_ar_valid), .ar_ready(m1_ar_ready), .ar_addr(m1_ar_addr),
		.r_valid(m1_r_valid), .r_ready(m1_r_ready), .r_data(m1_r_data), .r_resp(m1_r_resp),
		.aw_valid(m1_aw_valid), .aw_addr(m1_aw_addr), .w_valid(m1_w_valid),
		.w_data(m1_w_data), .w_strb(m1_w_strb), .b_ready(m1_b_ready),
		.busy, .pixel_valid, .pixel_word, .frame_done
	);
endmodule

// ==== bench/soc_tb.sv ====
// SoC testbench with a shadow memory model, command port stimulus and pixel checking
module soc_tb import bus_pkg::*, gfx_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 200;
	localparam int FRAME_TIMEOUT = 5000;
	localparam int FB_IDX = 512;	// Framebuffer word index
	localparam int FB_LINES = 24;

	logic hdmi_pixClk = 1'b0;
	logic rst;
	logic cmd_aw_valid, cmd_w_valid, cmd_b_ready, cmd_ar_valid, cmd_r_ready;
	addr_t cmd_aw_addr, cmd_ar_addr;
	data_t cmd_w_data;
	strb_t cmd_w_strb;
	logic cmd_aw_ready, cmd_w_ready, cmd_b_valid, cmd_ar_ready, cmd_r_valid;
	resp_t cmd_b_resp, cmd_r_resp;
	data_t cmd_r_data;
	logic pixel_valid, frame_done;
	pixel_t pixel_word;

	data_t lcg_state = 32'h1588;
	data_t shadow [MEM_WORDS];
	int written[$];
	pixel_t pix_q[$];
	logic done_q[$];
	pixel_t got_pix;
	logic got_done;
	int scan_idx = 0;
	int scan_lines = 0;
	int pix_idx = 0;
	int frames_seen = 0;
	int checks = 0;
	int errors = 0;

	soc_top UUT (.*);

	always #10 hdmi_pixClk = ~hdmi_pixClk;

	function automatic data_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic data_t merge_ref(input data_t old, input data_t data, input strb_t strb);
		data_t mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old & ~mask) | (data & mask);
	endfunction

	// Response expected from the address map
	function automatic resp_t expected_resp(input addr_t addr);
		if (addr[31:MEM_ADDR_BITS] == MEM_BASE[31:MEM_ADDR_BITS])
			return RESP_OKAY;
		if (addr[31:GFX_ADDR_BITS] == GFX_BASE[31:GFX_ADDR_BITS])
			return RESP_OKAY;
		return RESP_DECERR;
	endfunction

	function automatic addr_t word_addr(input int idx);
		return MEM_BASE + (addr_t'(idx) << 2);
	endfunction

	task automatic check(input string name, input data_t exp, input data_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Error %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout while waiting for %s", what);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Verification failed");
		$finish;
	endtask

	task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
			output resp_t resp);
		int n;
		@(negedge hdmi_pixClk);
		cmd_aw_valid = 1'b1;
		cmd_aw_addr = addr;
		cmd_w_valid = 1'b1;
		cmd_w_data = data;
		cmd_w_strb = strb;
		n = 0;
		while (!(cmd_aw_ready && cmd_w_ready)) begin
			if (n == TIMEOUT)
				report_timeout("write request to be accepted");
			@(negedge hdmi_pixClk);
			n++;
		end
		@(negedge hdmi_pixClk);	// Accepted on the edge just passed
		cmd_aw_valid = 1'b0;
		cmd_w_valid = 1'b0;
		n = 0;
		while (!cmd_b_valid) begin
			if (n == TIMEOUT)
				report_timeout("write response");
			@(negedge hdmi_pixClk);
			n++;
		end
		resp = cmd_b_resp;
	endtask

	task automatic axil_read(input addr_t addr, output data_t data, output resp_t resp);
		int n;
		@(negedge hdmi_pixClk);
		cmd_ar_valid = 1'b1;
		cmd_ar_addr = addr;
		n = 0;
		while (!cmd_ar_ready) begin
			if (n == TIMEOUT)
				report_timeout("read request to be accepted");
			@(negedge hdmi_pixClk);
			n++;
		end
		@(negedge hdmi_pixClk);
		cmd_ar_valid = 1'b0;
		n = 0;
		while (!cmd_r_valid) begin
			if (n == TIMEOUT)
				report_timeout("read response");
			@(negedge hdmi_pixClk);
			n++;
		end
		data = cmd_r_data;
		resp = cmd_r_resp;
	endtask

	task automatic write_expect(input string name, input addr_t addr, input data_t data,
			input strb_t strb);
		resp_t resp;
		axil_write(addr, data, strb, resp);
		check({name, " bresp"}, expected_resp(addr), resp);
	endtask

	task automatic read_expect(input string name, input addr_t addr, input data_t exp);
		data_t data;
		resp_t resp;
		axil_read(addr, data, resp);
		check({name, " rresp"}, expected_resp(addr), resp);
		check(name, exp, data);
	endtask

	task automatic mem_store(input string name, input int idx, input data_t data, input strb_t strb);
		write_expect(name, word_addr(idx), data, strb);
		shadow[idx] = merge_ref(shadow[idx], data, strb);
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames_seen < target) begin
			if (n == FRAME_TIMEOUT)
				report_timeout("scanout frames");
			@(negedge hdmi_pixClk);
			n++;
		end
	endtask

	// Clear enable, poll STATUS until busy drops, then compare the frame count
	task automatic stop_scanout(input string name);
		data_t status;
		resp_t resp;
		int n;
		write_expect({name, " disable"}, GFX_BASE + REG_CTRL, 32'h0, 4'hF);
		axil_read(GFX_BASE + REG_STATUS, status, resp);
		n = 0;
		while (status[16]) begin
			if (n == TIMEOUT)
				report_timeout("scanout busy to drop");
			axil_read(GFX_BASE + REG_STATUS, status, resp);
			n++;
		end
		check(name, data_t'(frames_seen), {16'b0, status[15:0]});
	endtask

	always @(negedge hdmi_pixClk) begin
		if (!rst && pixel_valid) begin
			pix_q.push_back(pixel_word);
			done_q.push_back(frame_done);
		end else if (!rst && frame_done) begin
			errors++;
			$display("frame_done pulsed without a pixel");
		end
	end

	always @(negedge hdmi_pixClk) begin
		while (pix_q.size() != 0) begin
			got_pix = pix_q.pop_front();
			got_done = done_q.pop_front();
			check("pixel", shadow[scan_idx + pix_idx], got_pix);
			check("frame_done", pix_idx == scan_lines - 1, got_done);
			if (got_done)
				frames_seen++;
			if (got_done || pix_idx == scan_lines - 1)
				pix_idx = 0;
			else
				pix_idx++;
		end
	end

	initial begin
		data_t d;
		int idx;
		int base_frames;
		addr_t bad_addr [4];
		bad_addr = '{32'h0000_1000, 32'h0200_0100, 32'h0100_0000, 32'hFFFF_FFFC};
		rst = 1'b1;
		cmd_aw_valid = 1'b0;
		cmd_aw_addr = '0;
		cmd_w_valid = 1'b0;
		cmd_w_data = '0;
		cmd_w_strb = '0;
		cmd_b_ready = 1'b1;	// Responses always taken
		cmd_ar_valid = 1'b0;
		cmd_ar_addr = '0;
		cmd_r_ready = 1'b1;
		repeat (4) @(negedge hdmi_pixClk);
		rst = 1'b0;

		for (int i = 0; i < 48; i++) begin
			idx = lcg_next() >> 22;
			mem_store("rand write", idx, lcg_next(), 4'hF);
			written.push_back(idx);
		end
		foreach (written[i])
			read_expect("rand read", word_addr(written[i]), shadow[written[i]]);

		for (int i = 0; i < 16; i++) begin
			idx = written[i];
			d = lcg_next();
			mem_store("strobe write", idx, lcg_next(), d[31:28]);
			read_expect("strobe read", word_addr(idx), shadow[idx]);
		end

		mem_store("decerr setup", 0, lcg_next(), 4'hF);	// 0x1000 aliases this word
		foreach (bad_addr[i]) begin
			write_expect("decerr write", bad_addr[i], lcg_next(), 4'hF);
			read_expect("decerr read", bad_addr[i], '0);
		end
		read_expect("decerr memory", word_addr(0), shadow[0]);

		d = lcg_next() & ~32'h3;
		write_expect("fb_base write", GFX_BASE + REG_FB_BASE, d, 4'hF);
		read_expect("fb_base read", GFX_BASE + REG_FB_BASE, d);
		d = lcg_next();
		write_expect("line_words write", GFX_BASE + REG_LINE_WORDS, d, 4'hF);
		read_expect("line_words read", GFX_BASE + REG_LINE_WORDS, d);
		write_expect("line_words zero", GFX_BASE + REG_LINE_WORDS, 32'h0, 4'hF);
		read_expect("line_words zero read", GFX_BASE + REG_LINE_WORDS, 32'h0);
		write_expect("ctrl set", GFX_BASE + REG_CTRL, 32'hFFFF_FFFF, 4'hF);
		read_expect("ctrl set read", GFX_BASE + REG_CTRL, 32'h1);
		write_expect("ctrl clear", GFX_BASE + REG_CTRL, 32'h0, 4'hF);
		read_expect("ctrl clear read", GFX_BASE + REG_CTRL, 32'h0);
		write_expect("status write", GFX_BASE + REG_STATUS, lcg_next(), 4'hF);
		read_expect("status read", GFX_BASE + REG_STATUS, 32'h0);
		write_expect("unknown write", GFX_BASE + 32'h10, lcg_next(), 4'hF);
		read_expect("unknown read", GFX_BASE + 32'h10, 32'h0);

		for (int i = 0; i < FB_LINES; i++)
			mem_store("fb fill", FB_IDX + i, lcg_next(), 4'hF);
		scan_idx = FB_IDX;
		scan_lines = FB_LINES;
		pix_idx = 0;
		write_expect("scan lines", GFX_BASE + REG_LINE_WORDS, FB_LINES, 4'hF);
		write_expect("scan base", GFX_BASE + REG_FB_BASE, FB_IDX * 4 + 2, 4'hF);	// Low bits dropped
		write_expect("scan enable", GFX_BASE + REG_CTRL, 32'h1, 4'hF);
		wait_frames(3);
		stop_scanout("frame count");

		// Command traffic below the framebuffer while scanout runs
		base_frames = frames_seen;
		write_expect("busy enable", GFX_BASE + REG_CTRL, 32'h1, 4'hF);
		for (int i = 0; i < 24; i++) begin
			idx = lcg_next() >> 24;
			mem_store("busy write", idx, lcg_next(), 4'hF);
			read_expect("busy read", word_addr(idx), shadow[idx]);
		end
		read_expect("busy fb_base", GFX_BASE + REG_FB_BASE, FB_IDX * 4 + 2);
		wait_frames(base_frames + 2);
		stop_scanout("busy frame count");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end
endmodule

// ==== list.f ====
hdl/bus_pkg.sv
hdl/gfx_pkg.sv
hdl/axil_ram.sv
hdl/axil_interconnect.sv
hdl/gfx_regs.sv
hdl/scanout_fetch.sv
hdl/soc_top.sv
bench/soc_tb.sv
